//--- source/gpu_frontend_pkg.sv
// Shared sizes, the opcode enum and the packed records of the
// instruction front end: fetch request, fetched instruction,
// decoded instruction and the decoder's next-PC report

package gpu_frontend_pkg;

    // ####################################################################
    // Sizes
    // ####################################################################

    localparam int unsigned num_warps      = 4;
    localparam int unsigned warp_width     = 8;
    localparam int unsigned pc_width       = 8;
    localparam int unsigned mem_size       = 64;
    localparam int unsigned buf_depth      = 4;

    // Derived widths
    localparam int unsigned wid_width      = $clog2(num_warps);
    localparam int unsigned mem_addr_width = $clog2(mem_size);
    localparam int unsigned inst_width     = 32;
    localparam int unsigned reg_width      = 6;

    // ####################################################################
    // Basic types
    // ####################################################################

    typedef logic [wid_width-1:0]  wid_t;
    typedef logic [pc_width-1:0]   pc_t;
    typedef logic [warp_width-1:0] act_mask_t;
    typedef logic [inst_width-1:0] enc_inst_t;
    typedef logic [reg_width-1:0]  reg_idx_t;

    // Opcode in bits 31:26, anything above EXIT is illegal
    typedef enum logic [5:0] {
        ILLEGAL = 6'd0,
        ADD,
        SUB,
        AND,
        OR,
        BRA,
        EXIT
    } opcode_e;

    // ####################################################################
    // Records
    // ####################################################################

    // Fetcher output, 18 bits
    typedef struct packed {
        wid_t      wid;
        pc_t       pc;
        act_mask_t act_mask;
    } fetch_req_t;

    // Buffer payload, 50 bits
    typedef struct packed {
        fetch_req_t req;
        enc_inst_t  inst;
    } fetched_inst_t;

    // Decoded output record, 50 bits
    typedef struct packed {
        wid_t      wid;
        pc_t       pc;
        act_mask_t act_mask;
        opcode_e   op;
        reg_idx_t  dst;
        reg_idx_t  src1;
        reg_idx_t  src2;
        logic [7:0] imm;
    } decoded_inst_t;

    // Next-PC report to the fetcher, 11 bits
    typedef struct packed {
        wid_t wid;
        pc_t  next_pc;
        logic retire;
    } resolve_t;

endpackage : gpu_frontend_pkg

//--- source/warp_fetcher.sv
// Warp fetcher: per-warp PC, mask, active and waiting state,
// launch handling and round-robin issue of one PC per cycle

`timescale 1ns/1ps

module warp_fetcher (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    // Launch port
    input  logic                        launch_i,
    input  gpu_frontend_pkg::wid_t      launch_wid_i,
    input  gpu_frontend_pkg::pc_t       launch_pc_i,
    input  gpu_frontend_pkg::act_mask_t launch_mask_i,
    // Resolve from decoder
    input  logic                        res_valid_i,
    input  gpu_frontend_pkg::resolve_t  res_i,
    // Request to lookup
    input  logic                        fe_ready_i,
    output logic                        fe_valid_o,
    output gpu_frontend_pkg::fetch_req_t fe_req_o,
    output logic                        warps_active_o
);
    import gpu_frontend_pkg::*;

    // ####################################################################
    // Warp table
    // ####################################################################

    pc_t                  pc_q   [num_warps];
    act_mask_t            mask_q [num_warps];
    logic [num_warps-1:0] active_q;
    // Set from issue until the decoder resolves the instruction
    logic [num_warps-1:0] waiting_q;

    // Round-robin pointer and the held choice
    wid_t ptr_q;
    logic hold_valid_q;
    wid_t hold_wid_q;

    logic pick_found;
    wid_t pick_wid;
    wid_t cur_wid;

    // ####################################################################
    // Round-robin pick
    // ####################################################################

    // First eligible warp at or after the pointer
    always_comb begin
        wid_t cand;
        pick_found = 1'b0;
        pick_wid   = ptr_q;
        for (int i = 0; i < num_warps; i++) begin
            cand = ptr_q + wid_t'(i);
            if (!pick_found && active_q[cand] && !waiting_q[cand]) begin
                pick_found = 1'b1;
                pick_wid   = cand;
            end
        end
    end

    // Stalled request keeps its warp until accepted
    assign cur_wid    = hold_valid_q ? hold_wid_q : pick_wid;
    assign fe_valid_o = hold_valid_q || pick_found;

    assign fe_req_o.wid      = cur_wid;
    assign fe_req_o.pc       = pc_q[cur_wid];
    assign fe_req_o.act_mask = mask_q[cur_wid];

    assign warps_active_o = |active_q;

    // ####################################################################
    // State update
    // ####################################################################

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            active_q     <= '0;
            waiting_q    <= '0;
            ptr_q        <= '0;
            hold_valid_q <= 1'b0;
            hold_wid_q   <= '0;
        end else begin
            if (fe_valid_o && fe_ready_i) begin
                // Issued, wait for resolve and move past this warp
                waiting_q[cur_wid] <= 1'b1;
                ptr_q              <= cur_wid + 1'b1;
                hold_valid_q       <= 1'b0;
            end else if (fe_valid_o) begin
                hold_valid_q <= 1'b1;
                hold_wid_q   <= cur_wid;
            end
            if (res_valid_i) begin
                waiting_q[res_i.wid] <= 1'b0;
                if (res_i.retire) begin
                    active_q[res_i.wid] <= 1'b0;
                end
            end
            if (launch_i) begin
                active_q[launch_wid_i] <= 1'b1;
            end
        end
    end

    // PC and mask per warp
    always_ff @(posedge clk_i) begin
        if (launch_i) begin
            pc_q[launch_wid_i]   <= launch_pc_i;
            mask_q[launch_wid_i] <= launch_mask_i;
        end
        if (res_valid_i && !res_i.retire) begin
            pc_q[res_i.wid] <= res_i.next_pc;
        end
    end

    // ####################################################################
    // Checks
    // ####################################################################

    // Launch only to a retired or never started warp
    a_launch_inactive: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        launch_i |-> !active_q[launch_wid_i])
        else $error("launch to active warp %0d", launch_wid_i);

    // Decoder resolves only warps with an instruction in flight
    a_resolve_waiting: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        res_valid_i |-> waiting_q[res_i.wid])
        else $error("resolve for warp %0d not waiting", res_i.wid);

endmodule : warp_fetcher

//--- source/instruction_lookup.sv
// Instruction lookup: program memory with a write port and a
// combinational read that bundles the request fields with the word

`timescale 1ns/1ps

module instruction_lookup (
    input  logic                            clk_i,
    // Program load
    input  logic                            mem_write_i,
    input  gpu_frontend_pkg::pc_t           mem_pc_i,
    input  gpu_frontend_pkg::enc_inst_t     mem_inst_i,
    // From fetcher
    input  logic                            fe_valid_i,
    input  gpu_frontend_pkg::fetch_req_t    fe_req_i,
    output logic                            fe_ready_o,
    // To buffer
    input  logic                            buf_ready_i,
    output logic                            lk_valid_o,
    output gpu_frontend_pkg::fetched_inst_t lk_inst_o
);
    import gpu_frontend_pkg::*;

    enc_inst_t prog_mem [mem_size];

    // Load port, only used while idle
    always_ff @(posedge clk_i) begin
        if (mem_write_i) begin
            prog_mem[mem_pc_i[mem_addr_width-1:0]] <= mem_inst_i;
        end
    end

    a_write_in_range: assert property (@(posedge clk_i)
        mem_write_i |-> mem_pc_i < pc_t'(mem_size))
        else $error("program write beyond memory, pc %0d", mem_pc_i);

    // Handshake passes straight through
    assign fe_ready_o = buf_ready_i;
    assign lk_valid_o = fe_valid_i;

    // Out of range reads give zero, which decodes as ILLEGAL
    assign lk_inst_o.req  = fe_req_i;
    assign lk_inst_o.inst = (fe_req_i.pc < pc_t'(mem_size))
                          ? prog_mem[fe_req_i.pc[mem_addr_width-1:0]] : '0;

endmodule : instruction_lookup

//--- source/instruction_buffer.sv
// Instruction buffer: circular FIFO of fetched instructions with
// valid/ready on both sides and an empty flag for the idle logic

`timescale 1ns/1ps

module instruction_buffer (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    // Push side
    input  logic                            push_valid_i,
    input  gpu_frontend_pkg::fetched_inst_t push_i,
    output logic                            push_ready_o,
    // Pop side
    input  logic                            pop_ready_i,
    output logic                            pop_valid_o,
    output gpu_frontend_pkg::fetched_inst_t pop_o,
    output logic                            empty_o
);
    import gpu_frontend_pkg::*;

    localparam int unsigned ptr_width = $clog2(buf_depth);

    typedef logic [ptr_width-1:0] ptr_t;
    typedef logic [ptr_width:0]   cnt_t;

    fetched_inst_t entries [buf_depth];
    ptr_t          wr_ptr_q;
    ptr_t          rd_ptr_q;
    cnt_t          count_q;

    logic full;
    logic push_fire;
    logic pop_fire;

    assign full    = (count_q == cnt_t'(buf_depth));
    assign empty_o = (count_q == '0);

    // Full buffer still takes a push when the head leaves
    assign push_ready_o = !full || pop_ready_i;
    assign pop_valid_o  = !empty_o;
    assign pop_o        = entries[rd_ptr_q];

    assign push_fire = push_valid_i && push_ready_o;
    assign pop_fire  = pop_valid_o && pop_ready_i;

    // ####################################################################
    // Pointers and count
    // ####################################################################

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_fire) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_fire) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            count_q <= count_q + cnt_t'(push_fire) - cnt_t'(pop_fire);
        end
    end

    // Storage
    always_ff @(posedge clk_i) begin
        if (push_fire) begin
            entries[wr_ptr_q] <= push_i;
        end
    end

    // Overflow or underflow both carry the count past the depth
    a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        count_q <= cnt_t'(buf_depth))
        else $error("instruction buffer count out of range");

endmodule : instruction_buffer

//--- source/instruction_decoder.sv
// Instruction decoder: field split, next-PC resolution back to the
// fetcher and a one-entry output register with valid/ready

`timescale 1ns/1ps

module instruction_decoder (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    // From buffer
    input  logic                            in_valid_i,
    input  gpu_frontend_pkg::fetched_inst_t in_i,
    output logic                            in_ready_o,
    // To fetcher
    output logic                            res_valid_o,
    output gpu_frontend_pkg::resolve_t      res_o,
    // Decoded output
    input  logic                            out_ready_i,
    output logic                            out_valid_o,
    output gpu_frontend_pkg::decoded_inst_t out_inst_o
);
    import gpu_frontend_pkg::*;

    logic [5:0]    op_raw;
    opcode_e       op;
    decoded_inst_t dec;
    logic          pop;

    logic          out_valid_q;
    decoded_inst_t out_inst_q;

    // ####################################################################
    // Field decode
    // ####################################################################

    assign op_raw = in_i.inst[31:26];
    // Unknown opcodes fold to ILLEGAL
    assign op     = (op_raw > 6'(EXIT)) ? ILLEGAL : opcode_e'(op_raw);

    assign dec.wid      = in_i.req.wid;
    assign dec.pc       = in_i.req.pc;
    assign dec.act_mask = in_i.req.act_mask;
    assign dec.op       = op;
    assign dec.dst      = in_i.inst[25:20];
    assign dec.src1     = in_i.inst[19:14];
    assign dec.src2     = in_i.inst[13:8];
    assign dec.imm      = in_i.inst[7:0];

    // ####################################################################
    // Next PC
    // ####################################################################

    // BRA jumps to imm, EXIT and ILLEGAL end the warp
    assign res_o.wid     = in_i.req.wid;
    assign res_o.next_pc = (op == BRA) ? pc_t'(dec.imm) : in_i.req.pc + 1'b1;
    assign res_o.retire  = (op == EXIT) || (op == ILLEGAL);

    // One resolve per pop, no back-pressure
    assign in_ready_o  = !out_valid_q || out_ready_i;
    assign pop         = in_valid_i && in_ready_o;
    assign res_valid_o = pop;

    // ####################################################################
    // Output register
    // ####################################################################

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            out_valid_q <= 1'b0;
        end else if (in_ready_o) begin
            out_valid_q <= in_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop) begin
            out_inst_q <= dec;
        end
    end

    assign out_valid_o = out_valid_q;
    assign out_inst_o  = out_inst_q;

    // Stalled record held until taken
    a_out_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_inst_o))
        else $error("decoded output changed under stall");

endmodule : instruction_decoder

//--- source/gpu_frontend.sv
// Front end top: fetcher, lookup, buffer and decoder, with the idle
// flag formed from warp, buffer and output state

`timescale 1ns/1ps

module gpu_frontend (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    // Program load
    input  logic                            mem_write_i,
    input  gpu_frontend_pkg::pc_t           mem_pc_i,
    input  gpu_frontend_pkg::enc_inst_t     mem_inst_i,
    // Launch
    input  logic                            launch_i,
    input  gpu_frontend_pkg::wid_t          launch_wid_i,
    input  gpu_frontend_pkg::pc_t           launch_pc_i,
    input  gpu_frontend_pkg::act_mask_t     launch_mask_i,
    // Decoded output
    input  logic                            out_ready_i,
    output logic                            out_valid_o,
    output gpu_frontend_pkg::decoded_inst_t out_inst_o,
    output logic                            idle_o
);
    import gpu_frontend_pkg::*;

    // Fetcher to lookup
    logic          fe_valid;
    logic          fe_ready;
    fetch_req_t    fe_req;
    // Lookup to buffer
    logic          lk_valid;
    logic          buf_ready;
    fetched_inst_t lk_inst;
    // Buffer to decoder
    logic          dec_valid;
    logic          dec_ready;
    fetched_inst_t dec_inst;
    // Decoder to fetcher
    logic          res_valid;
    resolve_t      res;

    logic          warps_active;
    logic          buf_empty;

    assign idle_o = !warps_active && buf_empty && !out_valid_o;

    warp_fetcher i_fetcher (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .launch_i       (launch_i),
        .launch_wid_i   (launch_wid_i),
        .launch_pc_i    (launch_pc_i),
        .launch_mask_i  (launch_mask_i),
        .res_valid_i    (res_valid),
        .res_i          (res),
        .fe_ready_i     (fe_ready),
        .fe_valid_o     (fe_valid),
        .fe_req_o       (fe_req),
        .warps_active_o (warps_active)
    );

    instruction_lookup i_lookup (
        .clk_i       (clk_i),
        .mem_write_i (mem_write_i),
        .mem_pc_i    (mem_pc_i),
        .mem_inst_i  (mem_inst_i),
        .fe_valid_i  (fe_valid),
        .fe_req_i    (fe_req),
        .fe_ready_o  (fe_ready),
        .buf_ready_i (buf_ready),
        .lk_valid_o  (lk_valid),
        .lk_inst_o   (lk_inst)
    );

    instruction_buffer i_buffer (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .push_valid_i (lk_valid),
        .push_i       (lk_inst),
        .push_ready_o (buf_ready),
        .pop_ready_i  (dec_ready),
        .pop_valid_o  (dec_valid),
        .pop_o        (dec_inst),
        .empty_o      (buf_empty)
    );

    instruction_decoder i_decoder (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (dec_valid),
        .in_i        (dec_inst),
        .in_ready_o  (dec_ready),
        .res_valid_o (res_valid),
        .res_o       (res),
        .out_ready_i (out_ready_i),
        .out_valid_o (out_valid_o),
        .out_inst_o  (out_inst_o)
    );

    // Program may change only with no warp in the pipe
    a_write_while_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_write_i |-> idle_o)
        else $error("program write while front end busy");

endmodule : gpu_frontend

//--- verif/gpu_frontend_checks.svh
// Reference model of the front end: decode and next-PC rules, program
// word lookup, the xorshift generator and the compare tasks

`ifndef GPU_FRONTEND_CHECKS_SVH
`define GPU_FRONTEND_CHECKS_SVH

// One xorshift32 step
function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
endfunction

// Model copy of the program, zero outside the memory
function automatic enc_inst_t ref_fetch(input pc_t pc);
    if (pc < pc_t'(mem_size)) begin
        return ref_mem[pc[5:0]];
    end
    return '0;
endfunction

// Encoding rule: op 31:26, dst 25:20, src1 19:14, src2 13:8, imm 7:0
function automatic decoded_inst_t ref_decode(input enc_inst_t inst, input wid_t wid,
                                             input pc_t pc, input act_mask_t mask);
    decoded_inst_t d;
    d.wid      = wid;
    d.pc       = pc;
    d.act_mask = mask;
    // Opcodes past EXIT count as ILLEGAL
    if (inst[31:26] > 6'(EXIT)) begin
        d.op = ILLEGAL;
    end else begin
        d.op = opcode_e'(inst[31:26]);
    end
    d.dst  = inst[25:20];
    d.src1 = inst[19:14];
    d.src2 = inst[13:8];
    d.imm  = inst[7:0];
    return d;
endfunction

// Resolve rule: BRA to imm, EXIT and ILLEGAL retire, else pc plus one
function automatic resolve_t ref_next(input decoded_inst_t d);
    resolve_t r;
    r.wid     = d.wid;
    r.retire  = (d.op == EXIT) || (d.op == ILLEGAL);
    r.next_pc = (d.op == BRA) ? d.imm : d.pc + 8'd1;
    return r;
endfunction

task automatic check_decoded(input decoded_inst_t actual, input decoded_inst_t expected);
    if (actual !== expected) begin
        $display("Mismatch at %0t: out_inst_o got %h expected %h",
                 $time, actual, expected);
        stop_run();
    end
endtask

task automatic check_flag(input logic actual, input logic expected, input string name);
    if (actual !== expected) begin
        $display("Mismatch at %0t: %s got %b expected %b", $time, name, actual, expected);
        stop_run();
    end
endtask

`endif

//--- verif/gpu_frontend_tb.sv
// Testbench for the instruction front end: clock and reset, program
// load, warp launches, random output stalls, a model that checks
// every accepted output, and a cycle limit

`timescale 1ns/1ps

module gpu_frontend_tb;
    import gpu_frontend_pkg::*;

    localparam int unsigned max_cycles = 4000;

    logic          clk_i;
    logic          rst_n_i;
    logic          mem_write_i;
    pc_t           mem_pc_i;
    enc_inst_t     mem_inst_i;
    logic          launch_i;
    wid_t          launch_wid_i;
    pc_t           launch_pc_i;
    act_mask_t     launch_mask_i;
    logic          out_ready_i;
    logic          out_valid_o;
    decoded_inst_t out_inst_o;
    logic          idle_o;

    // Model state, per warp PC, mask and still running
    enc_inst_t            ref_mem  [mem_size];
    pc_t                  exp_pc   [num_warps];
    act_mask_t            exp_mask [num_warps];
    logic [num_warps-1:0] exp_live;
    int unsigned          cycle_count = 0;
    logic [31:0]          rng_q;

    `include "gpu_frontend_checks.svh"

    gpu_frontend UUT (.*);

    task automatic stop_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    initial begin
        clk_i = 1'b0;
        forever begin
            #50 clk_i = ~clk_i;
        end
    end

    // Out of range cycle count ends the run
    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("Timeout: run did not finish within %0d cycles", max_cycles);
            stop_run();
        end
    end

    // Output stalls, roughly one cycle in four
    initial begin
        rng_q = 32'hcae2;
        out_ready_i <= 1'b0;
        forever begin
            @(posedge clk_i);
            rng_q = xorshift32(rng_q);
            out_ready_i <= rst_n_i && (rng_q[1:0] != 2'b00);
        end
    end

    // ####################################################################
    // Model and comparison
    // ####################################################################

    always @(posedge clk_i) begin
        wid_t          w;
        decoded_inst_t exp_inst;
        resolve_t      exp_res;
        if (!rst_n_i) begin
            exp_live = '0;
        end else begin
            if (out_valid_o && out_ready_i) begin
                w = out_inst_o.wid;
                if (!exp_live[w]) begin
                    $display("Output at %0t for warp %0d, which has nothing left to emit",
                             $time, w);
                    stop_run();
                end
                exp_inst = ref_decode(ref_fetch(exp_pc[w]), w, exp_pc[w], exp_mask[w]);
                check_decoded(out_inst_o, exp_inst);
                exp_res = ref_next(exp_inst);
                if (exp_res.retire) begin
                    exp_live[w] = 1'b0;
                end else begin
                    exp_pc[w] = exp_res.next_pc;
                end
            end
            // Launch seen by the DUT on this edge
            if (launch_i) begin
                exp_live[launch_wid_i] = 1'b1;
                exp_pc[launch_wid_i]   = launch_pc_i;
                exp_mask[launch_wid_i] = launch_mask_i;
            end
        end
    end

    // ####################################################################
    // Stimulus tasks
    // ####################################################################

    // Register fields follow the address, BRA carries its target in imm
    task automatic put_word(input pc_t a, input opcode_e op, input pc_t target = '0);
        logic [7:0] imm;
        imm = (op == BRA) ? target : {a[3:0], a[7:4]};
        ref_mem[a[5:0]] = {op, a[5:0], ~a[5:0], a[2:0], a[5:3], imm};
    endtask

    task automatic build_program();
        for (int a = 0; a < mem_size; a++) begin
            ref_mem[a] = '0;
        end
        // Straight-line ALU code
        put_word(8'd0, ADD);
        put_word(8'd1, SUB);
        put_word(8'd2, AND);
        put_word(8'd3, OR);
        put_word(8'd4, EXIT);
        // Branch chain, words after each BRA must not show up
        put_word(8'd8, BRA, 8'd12);
        put_word(8'd9, ADD);
        put_word(8'd10, ADD);
        put_word(8'd12, SUB);
        put_word(8'd13, BRA, 8'd16);
        put_word(8'd14, OR);
        put_word(8'd16, EXIT);
        // Runs into the empty word at 22
        put_word(8'd20, ADD);
        put_word(8'd21, SUB);
        // Jumps past the end of memory
        put_word(8'd30, AND);
        put_word(8'd31, BRA, 8'd200);
        // Undefined opcode after one ALU word
        put_word(8'd40, OR);
        ref_mem[41] = {6'h3f, 6'd7, 6'd9, 6'd11, 8'h5a};
    endtask

    task automatic load_program();
        for (int a = 0; a < mem_size; a++) begin
            @(posedge clk_i);
            mem_write_i <= 1'b1;
            mem_pc_i    <= pc_t'(a);
            mem_inst_i  <= ref_mem[a];
        end
        @(posedge clk_i);
        mem_write_i <= 1'b0;
    endtask

    task automatic launch_warp(input wid_t w, input pc_t pc, input act_mask_t mask);
        @(posedge clk_i);
        launch_i      <= 1'b1;
        launch_wid_i  <= w;
        launch_pc_i   <= pc;
        launch_mask_i <= mask;
        @(posedge clk_i);
        launch_i <= 1'b0;
    endtask

    // Busy right after launch, idle again once every warp retired
    task automatic finish_phase();
        @(posedge clk_i);
        check_flag(idle_o, 1'b0, "idle_o");
        wait (exp_live == '0);
        @(posedge clk_i);
        check_flag(idle_o, 1'b1, "idle_o");
    endtask

    initial begin
        rst_n_i       <= 1'b0;
        mem_write_i   <= 1'b0;
        mem_pc_i      <= '0;
        mem_inst_i    <= '0;
        launch_i      <= 1'b0;
        launch_wid_i  <= '0;
        launch_pc_i   <= '0;
        launch_mask_i <= '0;
        build_program();
        repeat (5) @(posedge clk_i);
        rst_n_i <= 1'b1;
        load_program();
        launch_warp(2'd0, 8'd0, 8'hff);
        finish_phase();
        launch_warp(2'd1, 8'd8, 8'h0f);
        finish_phase();
        // All four warps interleaved
        launch_warp(2'd0, 8'd40, 8'h81);
        launch_warp(2'd1, 8'd8, 8'h3c);
        launch_warp(2'd2, 8'd20, 8'h55);
        launch_warp(2'd3, 8'd30, 8'hf0);
        finish_phase();
        $display("PASS: all tests");
        $finish;
    end

endmodule : gpu_frontend_tb

//--- gpu_frontend.f
+incdir+verif
source/gpu_frontend_pkg.sv
source/warp_fetcher.sv
source/instruction_lookup.sv
source/instruction_buffer.sv
source/instruction_decoder.sv
source/gpu_frontend.sv
verif/gpu_frontend_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the front end testbench with Verilator, run it and look for
# the pass line in the log

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert \
    -f gpu_frontend.f \
    --top-module gpu_frontend_tb \
    -o gpu_frontend_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/gpu_frontend_sim > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "PASS: all tests" "$log_file"; then
    exit 0
fi
echo "Pass line not found in $log_file"
exit 1
